//--- hw/chi_pkg.sv
package chi_pkg;

    localparam int SRCID_W    = 11;
    localparam int TXNID_W    = 12;
    localparam int QOS_W      = 4;
    localparam int PCRDTYPE_W = 4;

    // request flit cut down to the fields used for admission
    typedef struct packed {
        logic [SRCID_W-1:0] srcid;
        logic [TXNID_W-1:0] txnid;
        logic [QOS_W-1:0]   qos;
        logic               allowretry;
    } req_flit_t;

    typedef struct packed {
        logic [SRCID_W-1:0]    srcid;
        logic [TXNID_W-1:0]    txnid;
        logic [QOS_W-1:0]      qos;
        logic [PCRDTYPE_W-1:0] pcrdtype;
    } retryack_t;

    typedef struct packed {
        logic [SRCID_W-1:0]    srcid;
        logic [QOS_W-1:0]      qos;
        logic [PCRDTYPE_W-1:0] pcrdtype;
    } pcrdgnt_t;

    // one bit per credit type
    localparam logic [PCRDTYPE_W-1:0] PCRD_LOW  = 4'b0001;
    localparam logic [PCRDTYPE_W-1:0] PCRD_HIGH = 4'b0010;

endpackage

//--- hw/hni_pkg.sv
package hni_pkg;

    import chi_pkg::*;

    // class split on the request qos field
    localparam logic [QOS_W-1:0] QOS_HIGH_MIN = 4'd8;
    localparam logic [QOS_W-1:0] QOS_LOW_MAX  = 4'd7;

    // qos carried on a credit grant
    localparam logic [QOS_W-1:0] GRANT_QOS_HIGH = 4'd15;
    localparam logic [QOS_W-1:0] GRANT_QOS_LOW  = 4'd0;

    typedef enum logic {
        QOS_CLASS_LOW  = 1'b0,
        QOS_CLASS_HIGH = 1'b1
    } qos_class_e;

    // refused dynamic request, as seen by the retry bank
    typedef struct packed {
        logic               valid;
        logic [SRCID_W-1:0] srcid;
        logic               high;
    } retry_rec_t;

    // retirement with the pool class stored for the entry
    typedef struct packed {
        logic       valid;
        qos_class_e cls;
    } retire_info_t;

endpackage

//--- hw/hni_rsp_fifo.sv
`timescale 1ns/1ps

module hni_rsp_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     valid,
    output payload_t data,
    input  logic     ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             pop;
    logic             push_ok;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign valid = (count_q != '0);
    assign data  = mem_q[rd_ptr_q];
    assign pop   = valid & ready;

    // full queue only takes a push when an item leaves
    assign push_ok = push & (~full | pop);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

endmodule

//--- hw/hni_qos_admit.sv
`timescale 1ns/1ps

module hni_qos_admit
    import chi_pkg::*;
    import hni_pkg::*;
#(
    parameter int HIGH_POOL_NUM = 2,
    parameter int LOW_POOL_NUM  = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid,
    input  req_flit_t    req,
    input  retire_info_t retire,
    input  logic         retire_reserve,
    input  logic         reserved_avail,
    output logic         alloc_en,
    output logic         retry,
    output qos_class_e   alloc_class,
    output logic         dyn_alloc,
    output retry_rec_t   retry_rec,
    output logic         retryack_push,
    output retryack_t    retryack_data
);

    localparam int POOL_MAX = (HIGH_POOL_NUM > LOW_POOL_NUM) ? HIGH_POOL_NUM : LOW_POOL_NUM;
    localparam int CNT_W    = $clog2(POOL_MAX + 1);

    logic       is_high;
    logic       req_dyn;
    logic       req_static;
    logic       use_high;
    logic       use_low;
    logic       can_alloc;
    // index 1 is the high pool, 0 the low pool
    logic [1:0] pool_sel;
    logic [1:0] pool_full_q;
    logic [1:0] pool_inc;
    logic [1:0] pool_dec;

    assign is_high    = (req.qos >= QOS_HIGH_MIN);
    assign req_dyn    = req_valid & req.allowretry;
    assign req_static = req_valid & ~req.allowretry;

    // high tries its own pool first, then borrows from low
    assign use_high  = is_high & ~pool_full_q[1];
    assign use_low   = ~use_high & ~pool_full_q[0];
    assign can_alloc = use_high | use_low;
    assign pool_sel  = {use_high, use_low};

    assign dyn_alloc   = req_dyn & can_alloc;
    assign retry       = req_dyn & ~can_alloc;
    assign alloc_en    = dyn_alloc | (req_static & reserved_avail);
    assign alloc_class = use_high ? QOS_CLASS_HIGH : QOS_CLASS_LOW;

    for (genvar g = 0; g < 2; g++) begin : g_pool
        localparam int NUM = (g == 1) ? HIGH_POOL_NUM : LOW_POOL_NUM;

        logic [CNT_W-1:0] cnt_q;
        logic [CNT_W-1:0] cnt_ns;

        assign pool_inc[g] = dyn_alloc & pool_sel[g];
        // reserved retirements keep their pool slot
        assign pool_dec[g] = retire.valid & ~retire_reserve & (retire.cls == qos_class_e'(g));
        assign cnt_ns      = pool_inc[g] ? cnt_q + 1'b1 : cnt_q - 1'b1;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt_q          <= '0;
                pool_full_q[g] <= 1'b0;
            end else if (pool_inc[g] ^ pool_dec[g]) begin
                cnt_q          <= cnt_ns;
                pool_full_q[g] <= (cnt_ns == CNT_W'(NUM));
            end
        end
    end

    assign retry_rec = '{valid: retry, srcid: req.srcid, high: is_high};

    assign retryack_push = retry;
    assign retryack_data = '{
        srcid:    req.srcid,
        txnid:    req.txnid,
        qos:      req.qos,
        pcrdtype: is_high ? PCRD_HIGH : PCRD_LOW
    };

endmodule

//--- hw/hni_mshr_tracker.sv
`timescale 1ns/1ps

module hni_mshr_tracker
    import hni_pkg::*;
#(
    parameter int  MSHR_ENTRIES = 4,
    localparam int IDX_W        = (MSHR_ENTRIES > 1) ? $clog2(MSHR_ENTRIES) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_en,
    input  logic             dyn_alloc,
    input  qos_class_e       alloc_class,
    input  logic             static_req,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  logic             retire_reserve,
    output logic [IDX_W-1:0] alloc_idx,
    output logic             reserved_avail,
    output retire_info_t     retire
);

    logic [MSHR_ENTRIES-1:0] busy_q;
    logic [MSHR_ENTRIES-1:0] rsvd_q;
    logic [MSHR_ENTRIES-1:0] static_used_q;
    logic [MSHR_ENTRIES-1:0] dyn_avail;
    logic [MSHR_ENTRIES-1:0] static_avail;
    logic [MSHR_ENTRIES-1:0] alloc_oh;
    logic [MSHR_ENTRIES-1:0] retire_oh;
    logic [MSHR_ENTRIES-1:0] rsvd_set;
    logic [IDX_W-1:0]        dyn_idx;
    logic [IDX_W-1:0]        static_idx;
    qos_class_e              cls_q [MSHR_ENTRIES];

    function automatic logic [IDX_W-1:0] lowest(input logic [MSHR_ENTRIES-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // reserved entries are held back for static requests
    assign dyn_avail    = ~busy_q & ~rsvd_q;
    assign static_avail = ~busy_q & rsvd_q;

    assign dyn_idx        = lowest(dyn_avail);
    assign static_idx     = lowest(static_avail);
    assign alloc_idx      = static_req ? static_idx : dyn_idx;
    assign reserved_avail = |static_avail;

    always_comb begin
        alloc_oh  = '0;
        retire_oh = '0;
        if (alloc_en) begin
            alloc_oh[alloc_idx] = 1'b1;
        end
        if (retire_valid) begin
            retire_oh[retire_idx] = 1'b1;
        end
    end

    assign rsvd_set = retire_oh & {MSHR_ENTRIES{retire_reserve}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q        <= '0;
            rsvd_q        <= '0;
            static_used_q <= '0;
        end else begin
            busy_q        <= (busy_q | alloc_oh) & ~retire_oh;
            // cleared the cycle after a static request takes the entry
            rsvd_q        <= (rsvd_q & ~static_used_q) | rsvd_set;
            static_used_q <= alloc_oh & {MSHR_ENTRIES{static_req}};
        end
    end

    // pool class of the dynamic owner, kept across static reuse
    always_ff @(posedge clk) begin
        if (dyn_alloc) begin
            cls_q[alloc_idx] <= alloc_class;
        end
    end

    assign retire = '{valid: retire_valid, cls: cls_q[retire_idx]};

endmodule

//--- hw/hni_retry_bank.sv
`timescale 1ns/1ps

module hni_retry_bank
    import chi_pkg::*;
    import hni_pkg::*;
#(
    parameter int RET_BANK_ENTRIES = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  retry_rec_t   retry_rec,
    input  retire_info_t retire,
    output logic         retire_reserve,
    output logic         grant_push,
    output pcrdgnt_t     grant_data
);

    localparam int IDX_W = (RET_BANK_ENTRIES > 1) ? $clog2(RET_BANK_ENTRIES) : 1;
    // waiting count per slot and class, saturates
    localparam int CNT_W = 4;

    logic [RET_BANK_ENTRIES-1:0] slot_v_q;
    logic [SRCID_W-1:0]          srcid_q [RET_BANK_ENTRIES];
    logic [CNT_W-1:0]            h_cnt_q [RET_BANK_ENTRIES];
    logic [CNT_W-1:0]            l_cnt_q [RET_BANK_ENTRIES];
    logic [IDX_W-1:0]            next_q;
    logic [RET_BANK_ENTRIES-1:0] match_vec;
    logic [RET_BANK_ENTRIES-1:0] next_oh;
    logic [RET_BANK_ENTRIES-1:0] h_inc;
    logic [RET_BANK_ENTRIES-1:0] l_inc;
    logic [RET_BANK_ENTRIES-1:0] h_dec;
    logic [RET_BANK_ENTRIES-1:0] l_dec;
    logic [RET_BANK_ENTRIES-1:0] h_live;
    logic [RET_BANK_ENTRIES-1:0] l_live;
    logic                        new_src;
    logic                        high_any;
    logic                        low_any;
    logic                        h_win;
    logic                        l_win;
    logic [IDX_W-1:0]            win_idx;
    logic                        win_v_q;
    logic                        win_high_q;
    logic [IDX_W-1:0]            win_idx_q;

    function automatic logic [IDX_W-1:0] lowest(input logic [RET_BANK_ENTRIES-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = RET_BANK_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [CNT_W-1:0] cnt_next(input logic [CNT_W-1:0] cnt,
                                                  input logic             inc,
                                                  input logic             dec);
        logic [CNT_W-1:0] nxt;
        nxt = cnt;
        if (inc && !dec && cnt != '1) begin
            nxt = cnt + 1'b1;
        end else if (dec && !inc) begin
            nxt = cnt - 1'b1;
        end
        return nxt;
    endfunction

    assign new_src = retry_rec.valid & ~(|match_vec);

    for (genvar i = 0; i < RET_BANK_ENTRIES; i++) begin : g_slot
        assign match_vec[i] = slot_v_q[i] & (srcid_q[i] == retry_rec.srcid);
        assign next_oh[i]   = (next_q == IDX_W'(i));
        assign h_inc[i]     = retry_rec.valid & retry_rec.high & match_vec[i];
        assign l_inc[i]     = retry_rec.valid & ~retry_rec.high & match_vec[i];
        assign h_dec[i]     = win_v_q & win_high_q & (win_idx_q == IDX_W'(i));
        assign l_dec[i]     = win_v_q & ~win_high_q & (win_idx_q == IDX_W'(i));

        // last waiter already being granted no longer counts
        assign h_live[i] = (h_cnt_q[i] != '0) & ~(h_dec[i] & (h_cnt_q[i] == CNT_W'(1)));
        assign l_live[i] = (l_cnt_q[i] != '0) & ~(l_dec[i] & (l_cnt_q[i] == CNT_W'(1)));

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                h_cnt_q[i] <= '0;
                l_cnt_q[i] <= '0;
            end else if (new_src && next_oh[i]) begin
                // overwritten slot restarts with this refusal
                h_cnt_q[i] <= {{(CNT_W-1){1'b0}}, retry_rec.high};
                l_cnt_q[i] <= {{(CNT_W-1){1'b0}}, ~retry_rec.high};
            end else begin
                h_cnt_q[i] <= cnt_next(h_cnt_q[i], h_inc[i], h_dec[i]);
                l_cnt_q[i] <= cnt_next(l_cnt_q[i], l_inc[i], l_dec[i]);
            end
        end

        always_ff @(posedge clk) begin
            if (new_src && next_oh[i]) begin
                srcid_q[i] <= retry_rec.srcid;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_v_q <= '0;
            next_q   <= '0;
        end else if (new_src) begin
            slot_v_q <= slot_v_q | next_oh;
            next_q   <= (next_q == IDX_W'(RET_BANK_ENTRIES - 1)) ? '0 : next_q + 1'b1;
        end
    end

    // high first, low only on a low-class retirement
    assign high_any       = |h_live;
    assign low_any        = |l_live;
    assign h_win          = retire.valid & high_any;
    assign l_win          = retire.valid & ~high_any & low_any & (retire.cls == QOS_CLASS_LOW);
    assign retire_reserve = h_win | l_win;
    assign win_idx        = h_win ? lowest(h_live) : lowest(l_live);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_v_q    <= 1'b0;
            win_high_q <= 1'b0;
        end else begin
            win_v_q    <= retire_reserve;
            win_high_q <= h_win;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_reserve) begin
            win_idx_q <= win_idx;
        end
    end

    assign grant_push = win_v_q;
    assign grant_data = '{
        srcid:    srcid_q[win_idx_q],
        qos:      win_high_q ? GRANT_QOS_HIGH : GRANT_QOS_LOW,
        pcrdtype: win_high_q ? PCRD_HIGH : PCRD_LOW
    };

endmodule

//--- hw/hni_qos_top.sv
`timescale 1ns/1ps

module hni_qos_top
    import chi_pkg::*;
    import hni_pkg::*;
#(
    parameter int  HIGH_POOL_NUM    = 2,
    parameter int  LOW_POOL_NUM     = 2,
    parameter int  MSHR_ENTRIES     = HIGH_POOL_NUM + LOW_POOL_NUM,
    parameter int  RET_BANK_ENTRIES = 4,
    parameter int  FIFO_DEPTH       = 4,
    localparam int IDX_W            = (MSHR_ENTRIES > 1) ? $clog2(MSHR_ENTRIES) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  req_flit_t        req,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    output logic             alloc_en,
    output logic [IDX_W-1:0] alloc_idx,
    output logic             retry,
    output logic             retryack_valid,
    output retryack_t        retryack,
    input  logic             retryack_ready,
    output logic             pcrdgnt_valid,
    output pcrdgnt_t         pcrdgnt,
    input  logic             pcrdgnt_ready
);

    retire_info_t retire;
    logic         retire_reserve;
    logic         reserved_avail;
    logic         dyn_alloc;
    qos_class_e   alloc_class;
    retry_rec_t   retry_rec;
    logic         retryack_push;
    retryack_t    retryack_data;
    logic         grant_push;
    pcrdgnt_t     grant_data;

    hni_qos_admit #(
        .HIGH_POOL_NUM (HIGH_POOL_NUM),
        .LOW_POOL_NUM  (LOW_POOL_NUM)
    ) u_admit (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .retire         (retire),
        .retire_reserve (retire_reserve),
        .reserved_avail (reserved_avail),
        .alloc_en       (alloc_en),
        .retry          (retry),
        .alloc_class    (alloc_class),
        .dyn_alloc      (dyn_alloc),
        .retry_rec      (retry_rec),
        .retryack_push  (retryack_push),
        .retryack_data  (retryack_data)
    );

    hni_mshr_tracker #(
        .MSHR_ENTRIES (MSHR_ENTRIES)
    ) u_tracker (
        .clk            (clk),
        .rst            (rst),
        .alloc_en       (alloc_en),
        .dyn_alloc      (dyn_alloc),
        .alloc_class    (alloc_class),
        .static_req     (req_valid & ~req.allowretry),
        .retire_valid   (retire_valid),
        .retire_idx     (retire_idx),
        .retire_reserve (retire_reserve),
        .alloc_idx      (alloc_idx),
        .reserved_avail (reserved_avail),
        .retire         (retire)
    );

    hni_retry_bank #(
        .RET_BANK_ENTRIES (RET_BANK_ENTRIES)
    ) u_retry_bank (
        .clk            (clk),
        .rst            (rst),
        .retry_rec      (retry_rec),
        .retire         (retire),
        .retire_reserve (retire_reserve),
        .grant_push     (grant_push),
        .grant_data     (grant_data)
    );

    hni_rsp_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (retryack_t)
    ) u_retryack_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (retryack_push),
        .push_data (retryack_data),
        .valid     (retryack_valid),
        .data      (retryack),
        .ready     (retryack_ready)
    );

    hni_rsp_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (pcrdgnt_t)
    ) u_pcrdgnt_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (grant_push),
        .push_data (grant_data),
        .valid     (pcrdgnt_valid),
        .data      (pcrdgnt),
        .ready     (pcrdgnt_ready)
    );

endmodule

//--- verif/hni_qos_assert.sv
`timescale 1ns/1ps

module hni_qos_assert #(
    parameter type payload_t = logic
) (
    input logic     clk,
    input logic     rst,
    input logic     push,
    input logic     full,
    input logic     pop,
    input logic     valid,
    input logic     ready,
    input payload_t data
);

    int unsigned fails = 0;

    // a push into a full queue needs a pop in the same cycle
    a_no_lost_push: assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop)
        else begin
            $error("push into a full queue without a pop, item lost");
            fails++;
        end

    a_idle_in_reset: assert property (@(posedge clk) rst |-> !valid)
        else begin
            $error("queue shows valid while in reset");
            fails++;
        end

    // stalled head stays put
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (valid && !ready) |=> (valid && $stable(data)))
        else begin
            $error("queue head changed while valid and not ready");
            fails++;
        end

endmodule

//--- verif/hni_qos_checker.sv
`timescale 1ns/1ps

module hni_qos_checker
    import chi_pkg::*;
#(
    parameter int IDX_W = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_en,
    input  logic [IDX_W-1:0] alloc_idx,
    input  logic             retry,
    input  logic             retryack_valid,
    input  retryack_t        retryack,
    input  logic             retryack_ready,
    input  logic             pcrdgnt_valid,
    input  pcrdgnt_t         pcrdgnt,
    input  logic             pcrdgnt_ready,
    output logic             pending,
    output int               errors
);

    retryack_t        ra_q[$];
    pcrdgnt_t         gnt_q[$];
    logic             armed = 1'b0;
    string            cur_name = "reset";
    logic             exp_en;
    logic [IDX_W-1:0] exp_idx;
    logic             exp_retry;
    retryack_t        exp_ra;
    logic             exp_gnt_v;
    pcrdgnt_t         exp_gnt;
    int               passed;
    int               failed;

    task automatic expect_row(input string name, input logic en, input logic [IDX_W-1:0] idx,
                              input logic rty, input retryack_t ra, input logic gnt_v,
                              input pcrdgnt_t gnt);
        cur_name  = name;
        exp_en    = en;
        exp_idx   = idx;
        exp_retry = rty;
        exp_ra    = ra;
        exp_gnt_v = gnt_v;
        exp_gnt   = gnt;
        armed     = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act,
                             inout int bad);
        if (exp !== act) begin
            $display("** Error %s: %s expected %0h actual %0h", cur_name, what, exp, act);
            bad++;
        end
    endtask

    task automatic print_counts();
        $display("rows passed: %0d, rows failed: %0d, errors: %0d", passed, failed, errors);
    endtask

    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (rst) begin
            ra_q.delete();
            gnt_q.delete();
            armed  = 1'b0;
            passed = 0;
            failed = 0;
            errors = 0;
        end else begin
            // queue heads are compared as they leave
            if (retryack_valid && retryack_ready && ra_q.size() != 0) begin
                check_val("retryack", 32'(ra_q[0]), 32'(retryack), bad);
                void'(ra_q.pop_front());
            end else if (retryack_valid && ra_q.size() == 0) begin
                $display("%s: retry ack is valid but none was expected", cur_name);
                bad++;
            end
            if (pcrdgnt_valid && pcrdgnt_ready && gnt_q.size() != 0) begin
                check_val("pcrdgnt", 32'(gnt_q[0]), 32'(pcrdgnt), bad);
                void'(gnt_q.pop_front());
            end else if (pcrdgnt_valid && gnt_q.size() == 0) begin
                $display("%s: credit grant is valid but none was expected", cur_name);
                bad++;
            end
            if (armed) begin
                check_val("alloc_en", 32'(exp_en), 32'(alloc_en), bad);
                check_val("retry", 32'(exp_retry), 32'(retry), bad);
                if (exp_en) begin
                    check_val("alloc_idx", 32'(exp_idx), 32'(alloc_idx), bad);
                end
                if (exp_retry) begin
                    ra_q.push_back(exp_ra);
                end
                if (exp_gnt_v) begin
                    gnt_q.push_back(exp_gnt);
                end
                $display("%-22s %s", cur_name, (bad == 0) ? "pass" : "fail");
                if (bad == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
                armed = 1'b0;
            end
            errors += bad;
        end
        pending = (ra_q.size() != 0) || (gnt_q.size() != 0);
    end

endmodule

//--- verif/tb_hni_qos.sv
`timescale 1ns/1ps

module tb_hni_qos
    import chi_pkg::*;
    import hni_pkg::*;
();

    localparam int MSHR_ENTRIES = 4;
    localparam int IDX_W        = $clog2(MSHR_ENTRIES);

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_REQ,
        OP_RETIRE
    } op_e;

    // one row is one clock cycle
    typedef struct packed {
        op_e                op;
        logic [SRCID_W-1:0] srcid;
        logic [QOS_W-1:0]   qos;
        logic               allowretry;
        logic [IDX_W-1:0]   retire_idx;
        logic               ra_ready;
        logic               gnt_ready;
        logic               exp_en;
        logic [IDX_W-1:0]   exp_idx;
        logic               exp_retry;
        logic               exp_gnt;
        logic [SRCID_W-1:0] gnt_src;
        logic               gnt_high;
    } row_t;

    logic             clk;
    logic             rst;
    logic             req_valid;
    req_flit_t        req;
    logic             retire_valid;
    logic [IDX_W-1:0] retire_idx;
    logic             alloc_en;
    logic [IDX_W-1:0] alloc_idx;
    logic             retry;
    logic             retryack_valid;
    retryack_t        retryack;
    logic             retryack_ready;
    logic             pcrdgnt_valid;
    pcrdgnt_t         pcrdgnt;
    logic             pcrdgnt_ready;
    logic             pending;
    int               errors;
    row_t             rows[$];
    string            names[$];
    int               seed;
    int               cycles;
    int               cycle_limit;
    int               total;

    hni_qos_top #(
        .HIGH_POOL_NUM    (2),
        .LOW_POOL_NUM     (2),
        .MSHR_ENTRIES     (MSHR_ENTRIES),
        .RET_BANK_ENTRIES (4),
        .FIFO_DEPTH       (4)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .retire_valid   (retire_valid),
        .retire_idx     (retire_idx),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .retry          (retry),
        .retryack_valid (retryack_valid),
        .retryack       (retryack),
        .retryack_ready (retryack_ready),
        .pcrdgnt_valid  (pcrdgnt_valid),
        .pcrdgnt        (pcrdgnt),
        .pcrdgnt_ready  (pcrdgnt_ready)
    );

    hni_qos_checker #(
        .IDX_W (IDX_W)
    ) u_chk (
        .clk            (clk),
        .rst            (rst),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .retry          (retry),
        .retryack_valid (retryack_valid),
        .retryack       (retryack),
        .retryack_ready (retryack_ready),
        .pcrdgnt_valid  (pcrdgnt_valid),
        .pcrdgnt        (pcrdgnt),
        .pcrdgnt_ready  (pcrdgnt_ready),
        .pending        (pending),
        .errors         (errors)
    );

    bind hni_rsp_fifo hni_qos_assert #(
        .payload_t (payload_t)
    ) u_assert (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .full  (full),
        .pop   (pop),
        .valid (valid),
        .ready (ready),
        .data  (data)
    );

    task automatic add_req(input string name, input int src, input int qos, input bit ar,
                           input bit ra, input bit gnt, input bit en, input int idx,
                           input bit rty);
        row_t r;
        r            = '0;
        r.op         = OP_REQ;
        r.srcid      = SRCID_W'(src);
        r.qos        = QOS_W'(qos);
        r.allowretry = ar;
        r.ra_ready   = ra;
        r.gnt_ready  = gnt;
        r.exp_en     = en;
        r.exp_idx    = IDX_W'(idx);
        r.exp_retry  = rty;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic add_retire(input string name, input int idx, input bit ra, input bit gnt,
                              input bit g, input int src, input bit high);
        row_t r;
        r            = '0;
        r.op         = OP_RETIRE;
        r.retire_idx = IDX_W'(idx);
        r.ra_ready   = ra;
        r.gnt_ready  = gnt;
        r.exp_gnt    = g;
        r.gnt_src    = SRCID_W'(src);
        r.gnt_high   = high;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic add_idle(input string name, input bit ra, input bit gnt);
        row_t r;
        r           = '0;
        r.op        = OP_IDLE;
        r.ra_ready  = ra;
        r.gnt_ready = gnt;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // pools of 2 and 2, four entries, four bank slots
    task automatic build_table();
        add_idle("after_reset", 0, 0);
        add_req("dyn_high_0", 1, 12, 1, 0, 0, 1, 0, 0);
        add_req("dyn_high_1", 2, 9, 1, 0, 0, 1, 1, 0);
        add_req("dyn_low_0", 3, 3, 1, 0, 0, 1, 2, 0);
        add_req("dyn_low_1", 4, 5, 1, 0, 0, 1, 3, 0);
        add_retire("retire_free_1", 1, 0, 0, 0, 0, 0);
        add_req("reuse_high_1", 8, 15, 1, 0, 0, 1, 1, 0);
        add_req("refuse_high_a", 5, 10, 1, 0, 0, 0, 0, 1);
        add_req("refuse_low_a", 6, 2, 1, 0, 0, 0, 0, 1);
        add_req("refuse_high_b", 9, 8, 1, 0, 0, 0, 0, 1);
        add_req("refuse_low_b", 7, 0, 1, 0, 0, 0, 0, 1);
        // low retirement still grants the lowest high waiter
        add_retire("retire_low_2", 2, 1, 0, 1, 5, 1);
        add_idle("grant_push_a", 1, 0);
        add_req("static_src5", 5, 15, 0, 1, 0, 1, 2, 0);
        add_retire("retire_high_0", 0, 1, 0, 1, 9, 1);
        add_idle("grant_push_b", 1, 0);
        add_req("static_src9", 9, 15, 0, 1, 1, 1, 0, 0);
        add_retire("retire_low_3", 3, 1, 1, 1, 6, 0);
        add_idle("grant_push_c", 1, 1);
        add_req("static_src6", 6, 0, 0, 1, 1, 1, 3, 0);
        // high retirement with only a low waiter frees the pool
        add_retire("retire_high_1", 1, 1, 1, 0, 0, 0);
        add_req("dyn_high_again", 10, 11, 1, 1, 1, 1, 1, 0);
    endtask

    task automatic apply_row(input row_t r, input string name);
        retryack_t exp_ra;
        pcrdgnt_t  exp_gnt;
        req_valid      = (r.op == OP_REQ);
        retire_valid   = (r.op == OP_RETIRE);
        retire_idx     = r.retire_idx;
        retryack_ready = r.ra_ready;
        pcrdgnt_ready  = r.gnt_ready;
        req.srcid      = r.srcid;
        req.txnid      = TXNID_W'($random(seed));
        req.qos        = r.qos;
        req.allowretry = r.allowretry;
        // a refusal echoes the request with the credit type of its class
        exp_ra = '{
            srcid:    r.srcid,
            txnid:    req.txnid,
            qos:      r.qos,
            pcrdtype: (r.qos <= QOS_LOW_MAX) ? PCRD_LOW : PCRD_HIGH
        };
        exp_gnt = '{
            srcid:    r.gnt_src,
            qos:      r.gnt_high ? GRANT_QOS_HIGH : GRANT_QOS_LOW,
            pcrdtype: r.gnt_high ? PCRD_HIGH : PCRD_LOW
        };
        u_chk.expect_row(name, r.exp_en, r.exp_idx, r.exp_retry, exp_ra, r.exp_gnt, exp_gnt);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycle_limit > 0 && cycles >= cycle_limit) begin
                $display("timeout: run went past %0d cycles", cycle_limit);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    initial begin
        seed           = 71;
        cycles         = 0;
        cycle_limit    = 0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        retire_valid   = 1'b0;
        retire_idx     = '0;
        retryack_ready = 1'b0;
        pcrdgnt_ready  = 1'b0;
        build_table();
        cycle_limit = rows.size() * 8 + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            @(negedge clk);
            apply_row(rows[i], names[i]);
        end
        @(negedge clk);
        req_valid      = 1'b0;
        retire_valid   = 1'b0;
        retryack_ready = 1'b1;
        pcrdgnt_ready  = 1'b1;
        // wait for both queues to drain
        do begin
            @(negedge clk);
        end while (pending);
        u_chk.print_counts();
        total = errors + DUT.u_retryack_fifo.u_assert.fails + DUT.u_pcrdgnt_fifo.u_assert.fails;
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hw/chi_pkg.sv
hw/hni_pkg.sv
hw/hni_rsp_fifo.sv
hw/hni_qos_admit.sv
hw/hni_mshr_tracker.sv
hw/hni_retry_bank.sv
hw/hni_qos_top.sv
verif/hni_qos_assert.sv
verif/hni_qos_checker.sv
verif/tb_hni_qos.sv

//--- Bender.yml
package:
  name: hni_qos

sources:
  - files:
      - hw/chi_pkg.sv
      - hw/hni_pkg.sv
      - hw/hni_rsp_fifo.sv
      - hw/hni_qos_admit.sv
      - hw/hni_mshr_tracker.sv
      - hw/hni_retry_bank.sv
      - hw/hni_qos_top.sv
  - target: test
    files:
      - verif/hni_qos_assert.sv
      - verif/hni_qos_checker.sv
      - verif/tb_hni_qos.sv
